// ==== verilog.f ====
+incdir+design
design/masking_pkg.sv
design/chi_ctrl_pkg.sv
design/dom_and_2share.sv
design/rnd_lfsr.sv
design/masked_chi_row.sv
design/chi_row_ctrl.sv
design/masked_chi_top.sv
dv/tb_masked_chi_top.sv

// ==== Bender.yml ====
package:
  name: masked_chi

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/masking_pkg.sv
      - design/chi_ctrl_pkg.sv
      - design/dom_and_2share.sv
      - design/rnd_lfsr.sv
      - design/masked_chi_row.sv
      - design/chi_row_ctrl.sv
      - design/masked_chi_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/tb_masked_chi_top.sv

// ==== dv/tb_masked_chi_top.sv ====
//////////////////////////////
// self-checking testbench for
// the masked chi row top level
//////////////////////////////

`include "chi_cfg.svh"

module tb_masked_chi_top;

  import masking_pkg::*;

  // unmasked row with lane i at index i
  typedef share_t [`CHI_LANES-1:0] lanes_t;

  // one stimulus table entry
  typedef struct packed {
    lanes_t in_lanes;
    lanes_t exp_lanes;
    logic   busy_start;
  } entry_t;

  localparam int NUM_ENTRIES    = 8;
  localparam int JOB_CYCLES     = 6;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * JOB_CYCLES + 40;
  // latency of done_o from the start cycle
  localparam int DONE_LAT       = 3;

  logic        clk_i;
  logic        rst_n_i;
  logic        start_i;
  masked_row_t row_i;
  masked_row_t row_o;
  logic        busy_o;
  logic        done_o;

  entry_t table_q [NUM_ENTRIES];
  int     check_cnt  = 0;
  int     value_errs = 0;
  int     other_errs = 0;
  int     cycle_cnt  = 0;

  masked_chi_top dut_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .start_i (start_i),
    .row_i   (row_i),
    .row_o   (row_o),
    .busy_o  (busy_o),
    .done_o  (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////
  // checks and helpers
  //////////////////////////////

  task automatic check_lane(input string name, input share_t got, input share_t exp);
    check_cnt++;
    if (got !== exp) begin
      value_errs++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      value_errs++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  // fresh random s0 and an s1 that carries the lane value
  function automatic masked_row_t mask_row(input lanes_t lanes);
    masked_row_t mrow;
    for (int i = 0; i < `CHI_LANES; i++) begin
      mrow[i].s0 = share_t'($urandom());
      mrow[i].s1 = lanes[i] ^ mrow[i].s0;
    end
    return mrow;
  endfunction

  task automatic check_row(input lanes_t exp_lanes);
    for (int i = 0; i < `CHI_LANES; i++) begin
      check_lane($sformatf("row_o[%0d]", i), row_o[i].s0 ^ row_o[i].s1, exp_lanes[i]);
    end
  endtask

  // chi expectations worked out by hand with lane 4 first
  task automatic fill_table();
    table_q[0] = '{lanes_t'(0), lanes_t'(0), 1'b0};
    table_q[1] = '{{5{16'hFFFF}}, {5{16'hFFFF}}, 1'b0};
    table_q[2] = '{{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'hFFFF},
                   {16'h0000, 16'hFFFF, 16'h0000, 16'h0000, 16'hFFFF}, 1'b1};
    table_q[3] = '{{16'hFFFF, 16'h5555, 16'h3333, 16'h0F0F, 16'h00FF},
                   {16'hF0FF, 16'h5555, 16'h9999, 16'h4B4B, 16'h30CF}, 1'b0};
    table_q[4] = '{{16'h0F1E, 16'hDEF0, 16'h9ABC, 16'h5678, 16'h1234},
                   {16'h4B56, 16'hCED0, 16'h9BB2, 16'h1238, 16'h9AB0}, 1'b1};
    table_q[5] = '{{16'hAAAA, 16'h5555, 16'hAAAA, 16'h5555, 16'hAAAA},
                   {16'hFFFF, 16'h5555, 16'h0000, 16'h0000, 16'h0000}, 1'b0};
    table_q[6] = '{{16'h0010, 16'h0008, 16'h0004, 16'h0002, 16'h0001},
                   {16'h0012, 16'h0009, 16'h0014, 16'h000A, 16'h0005}, 1'b1};
    table_q[7] = '{{16'hFFFF, 16'h0000, 16'hFFFF, 16'h0000, 16'hFFFF},
                   {16'hFFFF, 16'h0000, 16'h0000, 16'h0000, 16'h0000}, 1'b0};
  endtask

  //////////////////////////////
  // one job
  //////////////////////////////

  // one start cycle then a wait for done and two quiet cycles
  task automatic run_job(input masked_row_t mrow, input logic busy_start,
                         input lanes_t exp_lanes);
    int          cyc;
    logic        got_done;
    masked_row_t junk;
    cyc      = 0;
    got_done = 1'b0;
    junk     = mask_row(lanes_t'({$urandom(), $urandom(), $urandom()}));
    @(posedge clk_i);
    #1;
    row_i   = mrow;
    start_i = 1'b1;
    @(negedge clk_i);
    check_bit("busy_o", busy_o, 1'b0);
    @(posedge clk_i);
    #1;
    // second start while busy carries a different row
    start_i = busy_start;
    if (busy_start) begin
      row_i = junk;
    end
    while (!got_done && cyc < DONE_LAT + 2) begin
      @(negedge clk_i);
      cyc++;
      if (done_o) begin
        got_done = 1'b1;
      end else begin
        check_bit("busy_o", busy_o, 1'b1);
        @(posedge clk_i);
        #1;
        start_i = 1'b0;
      end
    end
    if (!got_done) begin
      other_errs++;
      $display("done_o did not rise within %0d cycles of the start", cyc);
    end else if (cyc != DONE_LAT) begin
      other_errs++;
      $display("done_o rose %0d cycles after the start instead of %0d", cyc, DONE_LAT);
    end
    check_bit("busy_o", busy_o, 1'b0);
    check_row(exp_lanes);
    // pulse is one cycle wide and no extra job runs
    repeat (2) begin
      @(posedge clk_i);
      #1;
      start_i = 1'b0;
      @(negedge clk_i);
      check_bit("done_o", done_o, 1'b0);
      check_bit("busy_o", busy_o, 1'b0);
    end
  endtask

  // same masked row twice while the LFSR moves on in between
  task automatic check_remask();
    masked_row_t mrow;
    lanes_t      first_s0;
    lanes_t      second_s0;
    mrow = mask_row(table_q[4].in_lanes);
    run_job(mrow, 1'b0, table_q[4].exp_lanes);
    for (int i = 0; i < `CHI_LANES; i++) begin
      first_s0[i] = row_o[i].s0;
    end
    run_job(mrow, 1'b0, table_q[4].exp_lanes);
    for (int i = 0; i < `CHI_LANES; i++) begin
      second_s0[i] = row_o[i].s0;
    end
    check_cnt++;
    if (first_s0 == second_s0) begin
      other_errs++;
      $display("output s0 shares repeated for the same masked input row");
    end
  endtask

  task automatic print_counts();
    $display("checks %0d, value errors %0d, other errors %0d",
             check_cnt, value_errs, other_errs);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin : stimulus
    void'($urandom(54));
    rst_n_i  = 1'b0;
    start_i  = 1'b0;
    row_i    = '0;
    fill_table();
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    // quiet outputs after reset
    @(negedge clk_i);
    check_bit("done_o", done_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    check_row(lanes_t'(0));
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      run_job(mask_row(table_q[e].in_lanes), table_q[e].busy_start, table_q[e].exp_lanes);
    end
    check_remask();
    print_counts();
    if (value_errs == 0 && other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog on total run length
  initial begin : watchdog
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
    print_counts();
    $display("Test failed");
    $finish;
  end

endmodule

// ==== design/masked_chi_top.sv ====
//////////////////////////////
// masked chi row top level
//////////////////////////////

module masked_chi_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     start_i,
  input  masking_pkg::masked_row_t row_i,
  output masking_pkg::masked_row_t row_o,
  output logic                     busy_o,
  output logic                     done_o
);

  import masking_pkg::*;
  import chi_ctrl_pkg::*;

  // captured input row
  masked_row_t held_row;
  // combinational chi result
  masked_row_t chi_row;
  // fresh masks, new every cycle
  rnd_t        rnd;
  // reshare enable for all gadgets
  logic        z_valid;

  //////////////////////////////
  // sequencer
  //////////////////////////////

  chi_row_ctrl u_ctrl (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (start_i),
    .row_i      (row_i),
    .chi_row_i  (chi_row),
    .held_row_o (held_row),
    .z_valid_o  (z_valid),
    .row_o      (row_o),
    .busy_o     (busy_o),
    .done_o     (done_o)
  );

  //////////////////////////////
  // datapath and masks
  //////////////////////////////

  masked_chi_row u_chi_row (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .row_i     (held_row),
    .rnd_i     (rnd),
    .z_valid_i (z_valid),
    .row_o     (chi_row)
  );

  rnd_lfsr u_lfsr (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .rnd_o   (rnd)
  );

endmodule

// ==== design/chi_row_ctrl.sv ====
//////////////////////////////
// start/busy/done sequencer
// with input hold and output regs
//////////////////////////////

module chi_row_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     start_i,
  input  masking_pkg::masked_row_t row_i,
  input  masking_pkg::masked_row_t chi_row_i,
  output masking_pkg::masked_row_t held_row_o,
  output logic                     z_valid_o,
  output masking_pkg::masked_row_t row_o,
  output logic                     busy_o,
  output logic                     done_o
);

  import masking_pkg::*;
  import chi_ctrl_pkg::*;

  chi_state_e  state_q;
  chi_state_e  state_d;
  // row under work, fixed for the whole job
  masked_row_t held_q;
  // last finished result
  masked_row_t row_q;
  logic        done_q;
  // start seen while idle
  logic        start_ok;

  // starts during a job are dropped
  assign start_ok = start_i && (state_q == IDLE);

  //////////////////////////////
  // FSM
  //////////////////////////////

  // fixed three-state walk, no stalls
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (start_ok) begin
          state_d = RESHARE;
        end
      end
      RESHARE:   state_d = INTEGRATE;
      INTEGRATE: state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // one-cycle pulse, set on the edge that captures the result
      done_q  <= (state_q == INTEGRATE);
    end
  end

  //////////////////////////////
  // data registers
  //////////////////////////////

  // capture on accept, then hold until the next accept
  // gives the gadgets their two stable cycles
  always_ff @(posedge clk_i) begin
    if (start_ok) begin
      held_q <= row_i;
    end
  end

  // gadget outputs are valid in INTEGRATE
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      row_q <= '0;
    end else if (state_q == INTEGRATE) begin
      row_q <= chi_row_i;
    end
  end

  // outputs
  assign held_row_o = held_q;
  assign z_valid_o  = (state_q == RESHARE);
  assign busy_o     = (state_q != IDLE);
  assign done_o     = done_q;
  assign row_o      = row_q;

  // fixed latency, done exactly on the third edge after acceptance
  done_latency_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    start_ok |=> !done_o ##1 !done_o ##1 done_o
  );

  // the gadgets rely on this across reshare and integrate
  held_stable_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    busy_o |=> $stable(held_row_o)
  );

endmodule

// ==== design/masked_chi_row.sv ====
//////////////////////////////
// masked chi over one row,
// five DOM AND gadgets
//////////////////////////////

// chi: a[i] ^= ~a[i+1] & a[i+2], indices mod 5
// every share of the result stays in its own domain

`include "chi_cfg.svh"

module masked_chi_row (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  masking_pkg::masked_row_t row_i,
  input  chi_ctrl_pkg::rnd_t       rnd_i,
  input  logic                     z_valid_i,
  output masking_pkg::masked_row_t row_o
);

  import masking_pkg::*;

  for (genvar i = 0; i < `CHI_LANES; i++) begin : g_lane
    // complement of lane i+1
    masked_lane_t not_a;
    // gadget result for lane i
    masked_lane_t and_q;

    //////////////////////////////
    // masked NOT
    //////////////////////////////

    // inverting one share inverts the true value
    // s0 only, so s1 is untouched
    assign not_a.s0 = ~row_i[(i + 1) % `CHI_LANES].s0;
    assign not_a.s1 = row_i[(i + 1) % `CHI_LANES].s1;

    //////////////////////////////
    // masked AND
    //////////////////////////////

    // own slice of the random word for each gadget
    dom_and_2share u_dom_and (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .a_i       (not_a),
      .b_i       (row_i[(i + 2) % `CHI_LANES]),
      .z_i       (rnd_i[i*`CHI_LANE_W +: `CHI_LANE_W]),
      .z_valid_i (z_valid_i),
      .q_o       (and_q)
    );

    //////////////////////////////
    // masked XOR
    //////////////////////////////

    // linear step, done share by share
    assign row_o[i].s0 = row_i[i].s0 ^ and_q.s0;
    assign row_o[i].s1 = row_i[i].s1 ^ and_q.s1;
  end

endmodule

// ==== design/rnd_lfsr.sv ====
//////////////////////////////
// free-running Galois LFSR for
// the resharing masks
//////////////////////////////

`include "chi_cfg.svh"

module rnd_lfsr (
  input  logic               clk_i,
  input  logic               rst_n_i,
  output chi_ctrl_pkg::rnd_t rnd_o
);

  import chi_ctrl_pkg::*;

  rnd_t lfsr_q;
  rnd_t lfsr_d;

  //////////////////////////////
  // next state
  //////////////////////////////

  // right shift, feedback folded in through the tap mask
  always_comb begin
    lfsr_d = lfsr_q >> 1;
    // bit 0 leaving the register decides the feedback
    if (lfsr_q[0]) begin
      lfsr_d = lfsr_d ^ rnd_t'(`RND_TAPS);
    end
  end

  // advances on every clock, busy or not
  // so a repeated job sees a different mask
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lfsr_q <= rnd_t'(`RND_SEED);
    end else begin
      lfsr_q <= lfsr_d;
    end
  end

  // whole state goes out, one lane word per gadget
  // neighbouring words overlap after a shift, good enough for first order
  assign rnd_o = lfsr_q;

  // all-zero is the lock-up state of any LFSR
  lfsr_nonzero_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    lfsr_q != '0
  );

endmodule

// ==== design/dom_and_2share.sv ====
//////////////////////////////
// first-order DOM AND gadget,
// two shares, one reshare stage
//////////////////////////////

// q.s0 = a0 & b0 ^ [a0 & b1 ^ z]
// q.s1 = a1 & b1 ^ [a1 & b0 ^ z]
// bracketed terms are registered
// inputs must hold for two cycles, output valid one cycle after z_valid_i

module dom_and_2share (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  masking_pkg::masked_lane_t a_i,
  input  masking_pkg::masked_lane_t b_i,
  input  masking_pkg::share_t       z_i,
  input  logic                      z_valid_i,
  output masking_pkg::masked_lane_t q_o
);

  import masking_pkg::*;

  // inner-domain products
  share_t t_a0b0;
  share_t t_a1b1;
  // cross-domain products
  share_t t_a0b1;
  share_t t_a1b0;
  // remasked cross terms, before and after the register
  share_t t0_d;
  share_t t1_d;
  share_t t0_q;
  share_t t1_q;

  //////////////////////////////
  // products
  //////////////////////////////

  // each share stays in its own domain here
  assign t_a0b0 = a_i.s0 & b_i.s0;
  assign t_a1b1 = a_i.s1 & b_i.s1;

  // these mix both domains and must not reach the output unmasked
  assign t_a0b1 = a_i.s0 & b_i.s1;
  assign t_a1b0 = a_i.s1 & b_i.s0;

  //////////////////////////////
  // resharing
  //////////////////////////////

  // same z on both cross terms, cancels in s0 ^ s1
  assign t0_d = t_a0b1 ^ z_i;
  assign t1_d = t_a1b0 ^ z_i;

  // register stops glitches from combining both domains
  // loads only when the sequencer marks z as fresh
  always_ff @(posedge clk_i) begin
    if (z_valid_i) begin
      t0_q <= t0_d;
      t1_q <= t1_d;
    end
  end

  //////////////////////////////
  // integration
  //////////////////////////////

  // inner terms are combinational, so a and b must still be stable here
  assign q_o.s0 = t_a0b0 ^ t0_q;
  assign q_o.s1 = t_a1b1 ^ t1_q;

  // non-pipelined form, the inputs have to survive the reshare edge
  inputs_stable_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    z_valid_i |=> $stable(a_i) && $stable(b_i)
  );

  // the unmasked result is the plain AND of the unmasked inputs
  unmasked_and_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    z_valid_i |=> (q_o.s0 ^ q_o.s1) ==
      (($past(a_i.s0) ^ $past(a_i.s1)) & ($past(b_i.s0) ^ $past(b_i.s1)))
  );

endmodule

// ==== design/chi_ctrl_pkg.sv ====
//////////////////////////////
// controller states and the
// per-row randomness word
//////////////////////////////

`include "chi_cfg.svh"

package chi_ctrl_pkg;

  // fresh mask bits for one row
  // lane word i feeds gadget i
  typedef logic [`CHI_LANES*`CHI_LANE_W-1:0] rnd_t;

  //////////////////////////////
  // sequencer states
  //////////////////////////////

  // IDLE       waits for start
  // RESHARE    cross terms get remasked and registered
  // INTEGRATE  output shares are valid, result gets captured
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    RESHARE   = 2'd1,
    INTEGRATE = 2'd2
  } chi_state_e;

endpackage

// ==== design/masking_pkg.sv ====
//////////////////////////////
// Boolean share types for
// lanes and rows
//////////////////////////////

`include "chi_cfg.svh"

package masking_pkg;

  //////////////////////////////
  // share level
  //////////////////////////////

  // one share of one lane
  typedef logic [`CHI_LANE_W-1:0] share_t;

  //////////////////////////////
  // lane and row level
  //////////////////////////////

  // two shares, true value is s0 ^ s1
  // s0 sits in the upper half of the packed word
  typedef struct packed {
    share_t s0;
    share_t s1;
  } masked_lane_t;

  // full row, index i is lane i
  typedef masked_lane_t [`CHI_LANES-1:0] masked_row_t;

endpackage

// ==== design/chi_cfg.svh ====
//////////////////////////////
// lane geometry and LFSR constants
// for the masked chi row
//////////////////////////////

`ifndef CHI_CFG_SVH
`define CHI_CFG_SVH

// bits per lane, 8, 16, 32 or 64 all work
`define CHI_LANE_W 16

// chi mixes five lanes of one row
`define CHI_LANES 5

// LFSR reset state, any nonzero value
`define RND_SEED 80'h1234_5678_9ABC_DEF0_2468

// Galois mask for x^80 + x^79 + x^43 + x^42 + 1
// redo this polynomial when the lane width changes
`define RND_TAPS 80'hC000_0000_0600_0000_0000

`endif
